//--- src/blaster_pkg.sv
package blaster_pkg;

	//////////////////////////////////////////////////////////////////////
	// keypad readout, fire and charge status
	//////////////////////////////////////////////////////////////////////

	// keypad result, pressed flag plus low nibble of the key value
	typedef struct packed {
		logic       pressed; // a key is down
		logic [3:0] code;    // table code, 0..B
	} key_t;

	// fire window status
	typedef struct packed {
		logic fire_flag; // high inside the fire window
		logic fire_done; // sticky once the window closes
	} fire_state_t;

	// power-on charge then continuity
	typedef struct packed {
		logic charge;     // charger running
		logic continuity; // cap charged, watching the igniter
	} charge_state_t;

	//////////////////////////////////////////////////////////////////////
	// key codes
	//////////////////////////////////////////////////////////////////////

	localparam logic [3:0] KEY_TONE_FIRST   = 4'h1; // keys 1..8 play a tone
	localparam logic [3:0] KEY_TONE_LAST    = 4'h8;
	localparam logic [3:0] KEY_FORCE_CHARGE = 4'hA; // hold to run the charger
	localparam logic [3:0] KEY_FORCE_DUMP   = 4'hB; // hold to bleed the cap

	// speaker half periods in clocks, one per tone key
	// last entry doubles as the continuity tone
	localparam logic [15:0] TONE_HALF_PERIOD [0:7] = '{
		16'h2CCA,
		16'h27E7,
		16'h238D,
		16'h218E,
		16'h1DE5,
		16'h1AA2,
		16'h17BA,
		16'h1665
	};

	//////////////////////////////////////////////////////////////////////
	// timing defaults at 48 MHz
	//////////////////////////////////////////////////////////////////////

	localparam int DEBOUNCE_CYCLES_DEF = 480000;   // 10 ms
	localparam int FIRE_END_CYCLES_DEF = 64000000; // about 1.33 s
	localparam int SCAN_BITS_DEF       = 12;       // keypad divider width

endpackage

//--- src/keypad_scan.sv
module keypad_scan
	import blaster_pkg::*;
#(
	parameter int SCAN_BITS = SCAN_BITS_DEF
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [2:0] keypad_col, // active low
	output logic [3:0] keypad_row, // active low, one at a time
	output key_t       key
);

	localparam int SUB_BITS = SCAN_BITS - 2; // clocks per quarter, log2

	// sample point just before a quarter ends, rows long settled by then
	localparam logic [SUB_BITS-1:0] SAMPLE_AT = {{(SUB_BITS - 1){1'b1}}, 1'b0};

	// code by row then column
	localparam logic [3:0] KEY_MAP [0:3][0:2] = '{
		'{4'h3, 4'h2, 4'h1},
		'{4'h6, 4'h5, 4'h4},
		'{4'h9, 4'h8, 4'h7},
		'{4'hB, 4'h0, 4'hA}
	};

	logic [SCAN_BITS-1:0] div;     // scan divider
	logic [1:0]           quarter; // active row
	logic                 seen;    // key seen this period
	logic [2:0]           col_hit; // latched columns, active high
	logic [3:0]           row_hit; // latched row, active high
	logic [1:0]           col_idx;
	logic [1:0]           row_idx;
	logic                 any_hit;

	assign quarter = div[SCAN_BITS-1 -: 2];

	//////////////////////////////////////////////////////////////////////
	// row drive and column capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			div        <= '0;
			seen       <= 1'b0;
			col_hit    <= '0;
			row_hit    <= '0;
			keypad_row <= '1; // all rows idle
		end else begin
			div <= div + 1'b1;
			for (int i = 0; i < 4; i++) begin
				keypad_row[i] <= (quarter != 2'(i)); // low on our quarter
			end
			if (div == '0) begin
				seen <= 1'b0; // new period
			end else if (div == '1 && !seen) begin
				col_hit <= '0; // nothing down all period
				row_hit <= '0;
			end else if (div[SUB_BITS-1:0] == SAMPLE_AT && keypad_col != 3'b111) begin
				seen    <= 1'b1;
				col_hit <= ~keypad_col;
				row_hit <= ~keypad_row; // row currently driven
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// priority decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		col_idx = 2'd0;
		row_idx = 2'd3;
		if (col_hit[2]) col_idx = 2'd2;      // rightmost column wins
		else if (col_hit[1]) col_idx = 2'd1;
		if (row_hit[0]) row_idx = 2'd0;      // top row first
		else if (row_hit[1]) row_idx = 2'd1;
		else if (row_hit[2]) row_idx = 2'd2;
	end

	assign any_hit = (|col_hit) && (|row_hit);

	always_ff @(posedge clk) begin
		if (reset) begin
			key <= '0;
		end else begin
			key.pressed <= any_hit;
			key.code    <= any_hit ? KEY_MAP[row_idx][col_idx] : 4'h0;
		end
	end

endmodule

//--- src/fire_sequencer.sv
module fire_sequencer
	import blaster_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = DEBOUNCE_CYCLES_DEF,
	parameter int FIRE_END_CYCLES = FIRE_END_CYCLES_DEF
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        fire_button, // active high
	output fire_state_t fire
);

	//////////////////////////////////////////////////////////////////////
	// fire button debounce and fire window
	//
	// counter runs while the button is held, and once past debounce
	// the shot is committed, so release no longer matters
	//////////////////////////////////////////////////////////////////////

	localparam logic [27:0] FIRE_START = 28'(DEBOUNCE_CYCLES); // window opens
	localparam logic [27:0] FIRE_END   = 28'(FIRE_END_CYCLES); // window closes

	logic [27:0] fire_count;
	logic        committed;  // debounce passed
	logic        fire_flag;
	logic        fire_done;

	assign committed = (fire_count >= FIRE_START);

	always_ff @(posedge clk) begin
		if (reset) begin
			fire_count <= '0;
		end else if (fire_done) begin
			fire_count <= fire_count; // one shot per reset, stops re-fire on wrap
		end else if (!fire_button && !committed) begin
			fire_count <= '0; // bounce or short tap
		end else begin
			fire_count <= fire_count + 1'b1;
		end
	end

	// flag up at start count, down at end count
	always_ff @(posedge clk) begin
		if (reset) begin
			fire_flag <= 1'b0;
			fire_done <= 1'b0;
		end else begin
			if (fire_count == FIRE_START && !fire_done) begin
				fire_flag <= 1'b1;
			end else if (fire_count == FIRE_END) begin
				fire_flag <= 1'b0;
			end
			if (fire_count == FIRE_END) begin
				fire_done <= 1'b1; // sticky until reset, keeps dump on
			end
		end
	end

	assign fire.fire_flag = fire_flag;
	assign fire.fire_done = fire_done;

endmodule

//--- src/charge_control.sv
module charge_control
	import blaster_pkg::*;
#(
	parameter int SCAN_BITS = SCAN_BITS_DEF
) (
	input  logic          clk,
	input  logic          reset,
	input  logic [2:0]    iset,          // switch bits, active low
	input  logic          lt3420_done,   // charger finished
	input  logic          cont,          // igniter continuity seen
	input  fire_state_t   fire,
	input  key_t          key,
	output charge_state_t state,
	output logic          lt3420_charge,
	output logic          dump,
	output logic          arm_led,
	output logic          cont_led
);

	localparam int BLINK_BITS = SCAN_BITS + 13;

	logic                  charge;     // cap charging
	logic                  continuity; // waiting for fire
	logic [BLINK_BITS-1:0] blink;      // free running

	// power-on charge, then continuity, then idle after fire
	always_ff @(posedge clk) begin
		if (reset) begin
			charge     <= !iset[2]; // switch low enables auto charge
			continuity <= 1'b0;
		end else if (lt3420_done && charge) begin
			charge     <= 1'b0;
			continuity <= 1'b1;
		end else if (continuity && fire.fire_flag) begin
			charge     <= 1'b0;
			continuity <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) blink <= '0;
		else blink <= blink + 1'b1;
	end

	assign state         = '{charge: charge, continuity: continuity};
	assign arm_led       = charge && (blink[BLINK_BITS-1 -: 4] == 4'h0); // short blink
	assign cont_led      = continuity && cont;
	assign lt3420_charge = charge || (key.pressed && key.code == KEY_FORCE_CHARGE);
	// after fire, switch 1 low, or forced from keypad
	assign dump = fire.fire_done || !iset[1] || (key.pressed && key.code == KEY_FORCE_DUMP);

endmodule

//--- src/tone_gen.sv
module tone_gen
	import blaster_pkg::*;
(
	input  logic          clk,
	input  key_t          key,
	input  charge_state_t state,
	input  logic          cont,
	input  logic          mute,    // silences the continuity tone only
	output logic          speaker
);

	//////////////////////////////////////////////////////////////////////
	// square wave tone, phase toggles when the down counter hits zero
	//////////////////////////////////////////////////////////////////////

	// power-up values, speaker starts quiet
	logic [15:0] tone_cnt  = '0;
	logic        spk_en    = 1'b0;
	logic        spk_phase = 1'b0;

	logic        tone_key;  // keys 1..8
	logic        cont_tone; // igniter present and not muted
	logic [2:0]  tone_idx;
	logic [15:0] reload;
	logic        reload_en;

	assign tone_key  = key.pressed && key.code >= KEY_TONE_FIRST && key.code <= KEY_TONE_LAST;
	assign cont_tone = state.continuity && cont && !mute;
	assign tone_idx  = 3'(key.code - KEY_TONE_FIRST);

	// keypad beats continuity
	always_comb begin
		if (tone_key) begin
			reload_en = 1'b1;
			reload    = TONE_HALF_PERIOD[tone_idx];
		end else if (cont_tone) begin
			reload_en = 1'b1;
			reload    = TONE_HALF_PERIOD[7];
		end else begin
			reload_en = 1'b0; // silent, recheck next clock
			reload    = '0;
		end
	end

	// each phase lasts reload + 1 clocks
	always_ff @(posedge clk) begin
		if (tone_cnt == '0) begin
			spk_phase <= !spk_phase;
			spk_en    <= reload_en;
			tone_cnt  <= reload;
		end else begin
			tone_cnt <= tone_cnt - 1'b1;
		end
	end

	assign speaker = spk_phase & spk_en;

endmodule

//--- src/blaster_top.sv
module blaster_top
	import blaster_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = DEBOUNCE_CYCLES_DEF,
	parameter int FIRE_END_CYCLES = FIRE_END_CYCLES_DEF,
	parameter int SCAN_BITS       = SCAN_BITS_DEF
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       fire_button,
	input  logic [2:0] iset,          // active low switches
	input  logic       lt3420_done,
	input  logic       cont_n,        // continuity, active low
	input  logic [2:0] keypad_col,
	output logic [3:0] keypad_row,
	output logic       lt3420_charge,
	output logic       dump,
	output logic       arm_led,
	output logic       cont_led,
	output logic       speaker,
	output logic       speaker_n,
	output key_t       key            // keypad readout
);

	logic          cont;
	fire_state_t   fire;
	charge_state_t state;

	assign cont = !cont_n;

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	keypad_scan #(
		.SCAN_BITS(SCAN_BITS)
	) u_keypad (
		.clk       (clk),
		.reset     (reset),
		.keypad_col(keypad_col),
		.keypad_row(keypad_row),
		.key       (key)
	);

	//////////////////////////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////////////////////////

	fire_sequencer #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.FIRE_END_CYCLES(FIRE_END_CYCLES)
	) u_fire (
		.clk        (clk),
		.reset      (reset),
		.fire_button(fire_button),
		.fire       (fire)
	);

	charge_control #(
		.SCAN_BITS(SCAN_BITS)
	) u_charge (
		.clk          (clk),
		.reset        (reset),
		.iset         (iset),
		.lt3420_done  (lt3420_done),
		.cont         (cont),
		.fire         (fire),
		.key          (key),
		.state        (state),
		.lt3420_charge(lt3420_charge),
		.dump         (dump),
		.arm_led      (arm_led),
		.cont_led     (cont_led)
	);

	//////////////////////////////////////////////////////////////////////
	// result
	//////////////////////////////////////////////////////////////////////

	tone_gen u_tone (
		.clk    (clk),
		.key    (key),
		.state  (state),
		.cont   (cont),
		.mute   (iset[0]), // switch 0 mutes continuity beep
		.speaker(speaker)
	);

	assign speaker_n = !speaker; // differential drive, doubles the swing

endmodule

//--- verification/tb_clock.sv
module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial clk = 1'b0;

	// free running, first rising edge half a period in
	always #(PERIOD / 2) clk = !clk;

endmodule

//--- verification/blaster_tb.sv
module blaster_tb
	import blaster_pkg::*;
();

	localparam int DEBOUNCE_CYCLES = 40;
	localparam int FIRE_END_CYCLES = 400;
	localparam int SCAN_BITS       = 6;
	localparam int PERIOD          = 2 ** SCAN_BITS;       // one keypad scan
	localparam int BLINK_ON        = 2 ** (SCAN_BITS + 9); // arm led lit after reset
	localparam int TONE_MAX        = 16'h2CCA + 1;         // longest speaker phase

	localparam int TEST_CYCLES = 10 + BLINK_ON      // reset, arm blink
		+ 60 * PERIOD                               // 12 keys, 5 periods each
		+ 8 * TONE_MAX + 4 * PERIOD + 10            // key tone, continuity tone
		+ 8 * PERIOD + 4 * 22                       // forced keys, iset[1]
		+ 8 * (DEBOUNCE_CYCLES + 20) + FIRE_END_CYCLES + 110;
	localparam int LIMIT = TEST_CYCLES * 6 / 5;     // plus 20 percent

	// speaker half periods per tone key 1..8
	localparam logic [15:0] TONE_CLOCKS [0:7] = '{
		16'h2CCA, 16'h27E7, 16'h238D, 16'h218E,
		16'h1DE5, 16'h1AA2, 16'h17BA, 16'h1665
	};

	logic       clk;
	logic       reset;
	logic       fire_button;
	logic [2:0] iset;
	logic       lt3420_done;
	logic       cont_n;
	logic [2:0] keypad_col;
	logic [3:0] keypad_row;
	logic       lt3420_charge;
	logic       dump;
	logic       arm_led;
	logic       cont_led;
	logic       speaker;
	logic       speaker_n;
	key_t       key;

	logic       pad_down;            // keypad model, one key at a time
	logic [1:0] pad_row;
	logic [1:0] pad_col;
	int         key_errors    = 0;
	int         charge_errors = 0;
	int         bit_errors    = 0;
	int         period_errors = 0;
	int         cycle_count   = 0;
	int         since_reset   = 0;   // clocks since reset fell, drives blink model
	int unsigned seed;
	int unsigned seed_ret;

	tb_clock #(.PERIOD(100)) u_clock (.clk(clk));

	blaster_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.FIRE_END_CYCLES(FIRE_END_CYCLES),
		.SCAN_BITS      (SCAN_BITS)
	) u_dut (
		.clk(clk), .reset(reset), .fire_button(fire_button), .iset(iset),
		.lt3420_done(lt3420_done), .cont_n(cont_n), .keypad_col(keypad_col),
		.keypad_row(keypad_row), .lt3420_charge(lt3420_charge), .dump(dump),
		.arm_led(arm_led), .cont_led(cont_led), .speaker(speaker),
		.speaker_n(speaker_n), .key(key)
	);

	// pressed key shorts its column to its row while that row is driven low
	always_comb begin
		keypad_col = 3'b111;
		if (pad_down && !keypad_row[pad_row]) keypad_col[pad_col] = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// reference helpers and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [3:0] pad_code(input logic [1:0] row, input logic [1:0] col);
		if (row != 2'd3) return 4'(3 * row + 3 - col); // phone layout, 1 at the right
		case (col)
			2'd0:    return 4'hB;
			2'd1:    return 4'h0;
			default: return 4'hA;
		endcase
	endfunction

	task automatic check_key(input string name, input key_t exp, input key_t act);
		if (act !== exp) begin
			key_errors++;
			$display("Fail %s: expected pressed %b code %h, actual pressed %b code %h",
				name, exp.pressed, exp.code, act.pressed, act.code);
		end
	endtask

	task automatic check_charge(input string name, input charge_state_t exp);
		charge_state_t act;
		act.charge     = lt3420_charge;
		act.continuity = cont_led; // needs cont high to be visible
		if (act !== exp) begin
			charge_errors++;
			$display("Fail %s: expected charge %b cont %b, actual charge %b cont %b",
				name, exp.charge, exp.continuity, act.charge, act.continuity);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			bit_errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_period(input string name, input int exp, input int act);
		if (act != exp) begin
			period_errors++;
			$display("Fail %s: expected %0d clocks, actual %0d clocks", name, exp, act);
		end
	endtask

	task automatic press_code(input logic [3:0] code);
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (pad_code(2'(r), 2'(c)) == code) begin
					pad_row = 2'(r);
					pad_col = 2'(c);
				end
			end
		end
		pad_down = 1'b1;
	endtask

	task automatic wait_key(input logic pressed);
		while (key.pressed !== pressed) @(negedge clk);
	endtask

	// let an older tone's high phase run out, then time one high and one low phase
	task automatic check_tone(input string name, input int exp);
		int len;
		while (speaker !== 1'b0) @(negedge clk);
		while (speaker !== 1'b1) @(negedge clk);
		len = 0;
		while (speaker === 1'b1) begin
			len++;
			@(negedge clk);
		end
		check_period({name, " high"}, exp, len);
		len = 0;
		while (speaker === 1'b0) begin
			len++;
			@(negedge clk);
		end
		check_period({name, " low"}, exp, len);
	endtask

	task automatic report_counts();
		$display("errors: key %0d, charge %0d, bit %0d, period %0d",
			key_errors, charge_errors, bit_errors, period_errors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// monitors and timeout
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (since_reset > 0) begin
			check_bit("speaker_n", !speaker, speaker_n);
			check_bit("one row low", 1'b1, $countones(~keypad_row) == 1);
		end
	end

	always @(posedge clk) begin
		since_reset <= reset ? 0 : since_reset + 1;
		cycle_count <= cycle_count + 1;
		if (cycle_count > LIMIT) begin
			$display("Timeout: tests did not finish within %0d cycles", LIMIT);
			report_counts();
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [3:0] code;
		int         len;
		seed        = 32'hedfa_dfdc;
		seed_ret    = $urandom(seed);
		reset       = 1'b1;
		fire_button = 1'b0;
		iset        = 3'b010; // auto charge, no dump, continuity beep on
		lt3420_done = 1'b0;
		cont_n      = 1'b1;
		pad_down    = 1'b0;
		pad_row     = 2'd0;
		pad_col     = 2'd0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// power-on charge, arm led lit then dark
		@(negedge clk);
		check_charge("power on", {1'b1, 1'b0});
		check_bit("power on dump", 1'b0, dump);
		while (since_reset < BLINK_ON - 1) @(negedge clk);
		check_bit("arm lit", 1'b1, arm_led);
		@(negedge clk);
		check_bit("arm dark", 1'b0, arm_led);

		repeat (12) begin
			pad_row  = 2'($urandom % 4);
			pad_col  = 2'($urandom % 3);
			pad_down = 1'b1;
			repeat (3 * PERIOD) @(negedge clk);
			check_key("keypad press", {1'b1, pad_code(pad_row, pad_col)}, key);
			pad_down = 1'b0;
			repeat (2 * PERIOD) @(negedge clk);
			check_key("keypad release", {1'b0, 4'h0}, key);
		end

		code = 4'(1 + $urandom % 8); // tone keys 1..8
		press_code(code);
		wait_key(1'b1);
		check_key("tone key", {1'b1, code}, key);
		check_tone("key tone", TONE_CLOCKS[code - 1] + 1);
		pad_down = 1'b0;
		wait_key(1'b0);

		// charger done, continuity visible only with cont
		lt3420_done = 1'b1;
		@(negedge clk);
		lt3420_done = 1'b0;
		check_charge("charge done", {1'b0, 1'b0});
		check_bit("arm after charge", 1'b0, arm_led);
		repeat (2) begin
			cont_n = 1'b0;
			@(negedge clk);
			check_charge("cont present", {1'b0, 1'b1});
			cont_n = 1'b1;
			@(negedge clk);
			check_charge("cont absent", {1'b0, 1'b0});
		end
		cont_n = 1'b0;
		check_tone("continuity tone", TONE_CLOCKS[7] + 1);

		press_code(KEY_FORCE_DUMP);
		wait_key(1'b1);
		check_bit("force dump", 1'b1, dump);
		check_bit("force dump charge", 1'b0, lt3420_charge);
		pad_down = 1'b0;
		wait_key(1'b0);
		check_bit("force dump released", 1'b0, dump);
		press_code(KEY_FORCE_CHARGE);
		wait_key(1'b1);
		check_bit("force charge", 1'b1, lt3420_charge);
		check_bit("force charge dump", 1'b0, dump);
		pad_down = 1'b0;
		wait_key(1'b0);
		check_bit("force charge released", 1'b0, lt3420_charge);

		repeat (4) begin
			repeat (1 + $urandom % 20) @(negedge clk);
			iset = 3'($urandom) & 3'b101; // switch 1 low
			@(negedge clk);
			check_bit("iset1 low", 1'b1, dump);
			iset = 3'b010;
			@(negedge clk);
			check_bit("iset1 high", 1'b0, dump);
		end

		// taps shorter than debounce
		repeat (8) begin
			fire_button = 1'b1;
			repeat (1 + $urandom % (DEBOUNCE_CYCLES - 1)) @(negedge clk);
			fire_button = 1'b0;
			repeat (1 + $urandom % 20) @(negedge clk);
			check_bit("short pulse dump", 1'b0, dump);
			check_charge("short pulse cont", {1'b0, 1'b1});
		end

		fire_button = 1'b1;
		len = 0;
		while (cont_led) begin
			@(negedge clk);
			len++;
		end
		check_period("continuity end", DEBOUNCE_CYCLES + 2, len);
		fire_button = 1'b0; // committed, release changes nothing
		while (!dump) begin
			@(negedge clk);
			len++;
		end
		check_period("fire dump", FIRE_END_CYCLES + 1, len);
		repeat (100) @(negedge clk);
		check_bit("dump held", 1'b1, dump);
		check_charge("after fire", {1'b0, 1'b0});

		report_counts();
		if (key_errors + charge_errors + bit_errors + period_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- files.f
src/blaster_pkg.sv
src/keypad_scan.sv
src/fire_sequencer.sv
src/charge_control.sv
src/tone_gen.sv
src/blaster_top.sv
verification/tb_clock.sv
verification/blaster_tb.sv
